//--- cipher_ctrl_pkg.sv
// Shared constants and enum types for the AES cipher control unit, imported by every block
`default_nettype none

package cipher_ctrl_pkg;

  ////////////////////////////////
  // Round counts
  ////////////////////////////////

  // Round counter and round limit width
  localparam int unsigned RND_CTR_W = 4;

  // Rounds per key length as fixed by FIPS-197
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_128 = 4'd10;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_192 = 4'd12;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_256 = 4'd14;

  ////////////////////////////////
  // Command encodings
  ////////////////////////////////

  // Cipher direction
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Key length
  typedef enum logic [1:0] {
    AES_128 = 2'd0,
    AES_192 = 2'd1,
    AES_256 = 2'd2
  } key_len_e;

  // Control FSM states, code 3'd7 is unused and treated as a fault
  typedef enum logic [2:0] {
    CTRL_IDLE     = 3'd0,
    CTRL_INIT     = 3'd1,
    CTRL_ROUND    = 3'd2,
    CTRL_FINISH   = 3'd3,
    CTRL_CLEAR_S  = 3'd4,
    CTRL_CLEAR_KD = 3'd5,
    CTRL_ERROR    = 3'd6
  } cipher_state_e;

  ////////////////////////////////
  // Datapath selectors
  ////////////////////////////////

  typedef enum logic [1:0] {STATE_ROUND, STATE_INIT, STATE_CLEAR} state_sel_e;

  typedef enum logic [1:0] {ADD_RK_ROUND, ADD_RK_INIT, ADD_RK_FINAL} add_rk_sel_e;

  typedef enum logic [1:0] {
    KEY_FULL_ROUND,
    KEY_FULL_ENC_INIT,
    KEY_FULL_DEC_INIT,
    KEY_FULL_CLEAR
  } key_full_sel_e;

  typedef enum logic {KEY_DEC_EXPAND, KEY_DEC_CLEAR} key_dec_sel_e;

  // Which four 32-bit words of the full key feed AddRoundKey
  typedef enum logic [1:0] {
    KEY_WORDS_0123,
    KEY_WORDS_2345,
    KEY_WORDS_4567,
    KEY_WORDS_ZERO
  } key_words_sel_e;

  // Mixed form is the round key passed through InvMixColumns
  typedef enum logic {ROUND_KEY_DIRECT, ROUND_KEY_MIXED} round_key_sel_e;

endpackage

`default_nettype wire

//--- cipher_cmd_if.sv
// Bundle of latched command flags and their set and done strobes between FSM and command register
`timescale 1ns/100ps
`default_nettype none

interface cipher_cmd_if;

  // Latched flags of the operation in progress
  logic crypt;
  logic dec_key_gen;
  logic key_clear;
  logic data_out_clear;

  // Per-flag set pulses from the FSM
  logic set_crypt;
  logic set_dec_key_gen;
  logic set_key_clear;
  logic set_data_out_clear;

  // Clears all flags at the end of an operation
  logic done;

  modport reg_side (
    output crypt, dec_key_gen, key_clear, data_out_clear,
    input  set_crypt, set_dec_key_gen, set_key_clear, set_data_out_clear, done
  );

  modport fsm_side (
    input  crypt, dec_key_gen, key_clear, data_out_clear,
    output set_crypt, set_dec_key_gen, set_key_clear, set_data_out_clear, done
  );

endinterface

`default_nettype wire

//--- cipher_cmd_reg.sv
// Command flag register, holds what the current cipher operation is after acceptance
`timescale 1ns/100ps
`default_nettype none

module cipher_cmd_reg (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  cipher_cmd_if.reg_side  cmd
);

  logic any_set;

  assign any_set = cmd.set_crypt | cmd.set_dec_key_gen |
                   cmd.set_key_clear | cmd.set_data_out_clear;

  // Each flag is set on its own strobe, all drop together on done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd.crypt          <= 1'b0;
      cmd.dec_key_gen    <= 1'b0;
      cmd.key_clear      <= 1'b0;
      cmd.data_out_clear <= 1'b0;
    end else if (cmd.done) begin
      cmd.crypt          <= 1'b0;
      cmd.dec_key_gen    <= 1'b0;
      cmd.key_clear      <= 1'b0;
      cmd.data_out_clear <= 1'b0;
    end else begin
      if (cmd.set_crypt) begin
        cmd.crypt <= 1'b1;
      end
      if (cmd.set_dec_key_gen) begin
        cmd.dec_key_gen <= 1'b1;
      end
      if (cmd.set_key_clear) begin
        cmd.key_clear <= 1'b1;
      end
      if (cmd.set_data_out_clear) begin
        cmd.data_out_clear <= 1'b1;
      end
    end
  end

  // FSM must never start and finish an operation in the same cycle
  a_set_done_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmd.done && any_set));

endmodule

`default_nettype wire

//--- cipher_round_ctr.sv
// Round counter with per-key-length limit, flags the last regular round and counter faults
`timescale 1ns/100ps
`default_nettype none

module cipher_round_ctr
  import cipher_ctrl_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 load_i,
  input  wire key_len_e             key_len_i,
  input  wire logic                 incr_i,
  output logic      [RND_CTR_W-1:0] rnd_ctr_o,
  output logic                      last_regular_o,
  output logic                      rnd_ctr_err_o
);

  logic [RND_CTR_W-1:0] rnd_ctr_q;
  logic [RND_CTR_W-1:0] limit_q;
  logic [RND_CTR_W-1:0] limit_d;

  // Round limit for the requested key length
  always_comb begin
    case (key_len_i)
      AES_192: limit_d = NUM_ROUNDS_192;
      AES_256: limit_d = NUM_ROUNDS_256;
      default: limit_d = NUM_ROUNDS_128;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_ctr_q <= '0;
      limit_q   <= '0;
    end else if (load_i) begin
      // New block, restart from the initial round
      rnd_ctr_q <= '0;
      limit_q   <= limit_d;
    end else if (incr_i) begin
      rnd_ctr_q <= rnd_ctr_q + RND_CTR_W'(1);
    end
  end

  assign rnd_ctr_o = rnd_ctr_q;

  // Last regular round is one below the limit, the final round follows
  assign last_regular_o = (rnd_ctr_q >= (limit_q - RND_CTR_W'(1))) && (limit_q != '0);

  // Counter past the limit can only come from a fault
  assign rnd_ctr_err_o = rnd_ctr_q > limit_q;

  // Stepping past the limit is caught in the following cycle
  a_overrun_flagged: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (incr_i && !load_i && (rnd_ctr_q == limit_q)) |=> rnd_ctr_err_o);

endmodule

`default_nettype wire

//--- cipher_key_sel.sv
// Round key word and form decoder, driven by FSM phase, key length and cipher direction
`timescale 1ns/100ps
`default_nettype none

module cipher_key_sel
  import cipher_ctrl_pkg::*;
(
  input  wire cipher_state_e  state_i,
  input  wire logic           dec_key_gen_i,
  input  wire key_len_e       key_len_i,
  input  wire ciph_op_e       op_i,
  output key_words_sel_e      key_words_sel_o,
  output round_key_sel_e      round_key_sel_o
);

  logic inv;

  assign inv = (op_i == CIPH_INV);

  always_comb begin
    key_words_sel_o = KEY_WORDS_ZERO;
    if (!dec_key_gen_i) begin
      case (state_i)
        // Initial round, inverse starts from the top of the expanded key
        CTRL_INIT: begin
          case (key_len_i)
            AES_192: key_words_sel_o = inv ? KEY_WORDS_2345 : KEY_WORDS_0123;
            AES_256: key_words_sel_o = inv ? KEY_WORDS_4567 : KEY_WORDS_0123;
            default: key_words_sel_o = KEY_WORDS_0123;
          endcase
        end
        // Regular and final rounds, forward takes the freshly expanded words
        CTRL_ROUND, CTRL_FINISH: begin
          case (key_len_i)
            AES_192: key_words_sel_o = inv ? KEY_WORDS_0123 : KEY_WORDS_2345;
            AES_256: key_words_sel_o = inv ? KEY_WORDS_0123 : KEY_WORDS_4567;
            default: key_words_sel_o = KEY_WORDS_0123;
          endcase
        end
        // Idle, clear and error phases
        default: key_words_sel_o = KEY_WORDS_ZERO;
      endcase
    end
  end

  // Equivalent inverse cipher needs InvMixColumns on the regular round keys
  assign round_key_sel_o = ((state_i == CTRL_ROUND) && inv) ? ROUND_KEY_MIXED
                                                            : ROUND_KEY_DIRECT;

endmodule

`default_nettype wire

//--- cipher_ctrl_fsm.sv
// Main control FSM of the iterative AES cipher, sequences rounds and drives datapath strobes
`timescale 1ns/100ps
`default_nettype none

module cipher_ctrl_fsm
  import cipher_ctrl_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Command handshake
  input  wire logic       in_valid_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  input  wire logic       out_ready_i,
  // Command and fault
  input  wire ciph_op_e   op_i,
  input  wire key_len_e   key_len_i,
  input  wire logic       crypt_i,
  input  wire logic       dec_key_gen_i,
  input  wire logic       key_clear_i,
  input  wire logic       data_out_clear_i,
  input  wire logic       fault_i,
  output logic            alert_o,
  // Cipher datapath
  output state_sel_e      state_sel_o,
  output logic            state_we_o,
  output logic            sub_bytes_en_o,
  input  wire logic       sub_bytes_out_req_i,
  output logic            sub_bytes_out_ack_o,
  output add_rk_sel_e     add_rk_sel_o,
  // Key expansion datapath
  output key_full_sel_e   key_full_sel_o,
  output logic            key_full_we_o,
  output key_dec_sel_e    key_dec_sel_o,
  output logic            key_dec_we_o,
  output logic            key_expand_en_o,
  input  wire logic       key_expand_out_req_i,
  output logic            key_expand_out_ack_o,
  output logic            key_expand_clear_o,
  // Command register
  cipher_cmd_if.fsm_side  cmd,
  // Round counter
  output logic            rnd_load_o,
  output logic            rnd_incr_o,
  input  wire logic       last_regular_i,
  input  wire logic       rnd_ctr_err_i,
  output cipher_state_e   state_o
);

  cipher_state_e state_q;
  cipher_state_e state_d;
  logic          advance;

  always_comb begin
    // Everything idle unless a state says otherwise
    in_ready_o           = 1'b0;
    out_valid_o          = 1'b0;
    alert_o              = 1'b0;
    state_sel_o          = STATE_ROUND;
    state_we_o           = 1'b0;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;
    add_rk_sel_o         = ADD_RK_ROUND;
    key_full_sel_o       = KEY_FULL_ROUND;
    key_full_we_o        = 1'b0;
    key_dec_sel_o        = KEY_DEC_EXPAND;
    key_dec_we_o         = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;
    cmd.set_crypt          = 1'b0;
    cmd.set_dec_key_gen    = 1'b0;
    cmd.set_key_clear      = 1'b0;
    cmd.set_data_out_clear = 1'b0;
    cmd.done             = 1'b0;
    rnd_load_o           = 1'b0;
    rnd_incr_o           = 1'b0;
    advance              = 1'b0;
    state_d              = state_q;

    case (state_q)

      CTRL_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          if (key_clear_i || data_out_clear_i) begin
            cmd.set_key_clear      = key_clear_i;
            cmd.set_data_out_clear = data_out_clear_i;
            // Output registers are cleared through the state, so wipe it first
            state_d = data_out_clear_i ? CTRL_CLEAR_S : CTRL_CLEAR_KD;
          end else if (crypt_i || dec_key_gen_i) begin
            cmd.set_crypt       = crypt_i & ~dec_key_gen_i;
            cmd.set_dec_key_gen = dec_key_gen_i;
            // Load block, or wipe the state when only the key is wanted
            state_sel_o = dec_key_gen_i ? STATE_CLEAR : STATE_INIT;
            state_we_o  = 1'b1;
            // Load full key and restart key expansion
            key_full_sel_o = (!dec_key_gen_i && (op_i == CIPH_INV)) ? KEY_FULL_DEC_INIT
                                                                     : KEY_FULL_ENC_INIT;
            key_full_we_o      = 1'b1;
            key_expand_clear_o = 1'b1;
            rnd_load_o         = 1'b1;
            state_d            = CTRL_INIT;
          end else begin
            // Handshake without any command bit
            state_d = CTRL_ERROR;
          end
        end
      end

      CTRL_INIT: begin
        add_rk_sel_o = ADD_RK_INIT;
        if (key_len_i == AES_256) begin
          // Both first round keys are already in the full key register
          state_we_o = ~cmd.dec_key_gen;
          rnd_incr_o = 1'b1;
          state_d    = CTRL_ROUND;
        end else begin
          key_expand_en_o = 1'b1;
          if (key_expand_out_req_i) begin
            key_expand_out_ack_o = 1'b1;
            state_we_o           = ~cmd.dec_key_gen;
            key_full_we_o        = 1'b1;
            rnd_incr_o           = 1'b1;
            state_d              = CTRL_ROUND;
          end
        end
      end

      CTRL_ROUND: begin
        // Step with KeyExpand, and with SubBytes unless only the key is built
        advance = key_expand_out_req_i & (cmd.dec_key_gen | sub_bytes_out_req_i);
        sub_bytes_en_o  = cmd.crypt;
        key_expand_en_o = 1'b1;
        if (advance) begin
          sub_bytes_out_ack_o  = cmd.crypt;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = ~cmd.dec_key_gen;
          key_full_we_o        = 1'b1;
          rnd_incr_o           = 1'b1;
          if (last_regular_i) begin
            state_d = CTRL_FINISH;
            if (cmd.dec_key_gen) begin
              // Last round key is the decryption start key
              key_dec_we_o = 1'b1;
              // Try to finish right away, else wait in FINISH
              out_valid_o = 1'b1;
              if (out_ready_i) begin
                cmd.done = 1'b1;
                state_d  = CTRL_IDLE;
              end
            end
          end
        end
      end

      CTRL_FINISH: begin
        // Final round skips MixColumns
        add_rk_sel_o   = ADD_RK_FINAL;
        state_sel_o    = STATE_CLEAR;
        sub_bytes_en_o = cmd.crypt;
        advance        = sub_bytes_out_req_i | cmd.dec_key_gen;
        // Never release data while a fault is present
        out_valid_o    = advance & ~fault_i;
        if (out_valid_o && out_ready_i) begin
          sub_bytes_out_ack_o = cmd.crypt;
          // Output is taken, the state is no longer needed
          state_we_o = cmd.crypt;
          cmd.done   = 1'b1;
          state_d    = CTRL_IDLE;
        end
      end

      CTRL_CLEAR_S: begin
        state_sel_o = STATE_CLEAR;
        state_we_o  = 1'b1;
        state_d     = CTRL_CLEAR_KD;
      end

      CTRL_CLEAR_KD: begin
        if (cmd.key_clear) begin
          key_full_sel_o = KEY_FULL_CLEAR;
          key_full_we_o  = 1'b1;
          key_dec_sel_o  = KEY_DEC_CLEAR;
          key_dec_we_o   = 1'b1;
        end
        if (cmd.data_out_clear) begin
          // Pass the wiped state to the output registers unchanged
          add_rk_sel_o = ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          cmd.done = 1'b1;
          state_d  = CTRL_IDLE;
        end
      end

      // Terminal, left only by reset
      CTRL_ERROR: begin
        alert_o = 1'b1;
      end

      default: begin
        alert_o = 1'b1;
        state_d = CTRL_ERROR;
      end
    endcase

    // Faults override any transition
    if (fault_i || rnd_ctr_err_i) begin
      state_d = CTRL_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  ////////////////////////////////
  // Assertions
  ////////////////////////////////

  a_hs_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_ready_o && out_valid_o));

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {CTRL_IDLE, CTRL_INIT, CTRL_ROUND, CTRL_FINISH,
                    CTRL_CLEAR_S, CTRL_CLEAR_KD, CTRL_ERROR});

endmodule

`default_nettype wire

//--- cipher_ctrl_top.sv
// Top level of the AES cipher control unit, connects FSM, command register, counter and decoder
`timescale 1ns/100ps
`default_nettype none

module cipher_ctrl_top
  import cipher_ctrl_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Command handshake
  input  wire logic                 in_valid_i,
  output logic                      in_ready_o,
  output logic                      out_valid_o,
  input  wire logic                 out_ready_i,
  // Command, held stable while a block is in flight
  input  wire ciph_op_e             op_i,
  input  wire key_len_e             key_len_i,
  input  wire logic                 crypt_i,
  input  wire logic                 dec_key_gen_i,
  input  wire logic                 key_clear_i,
  input  wire logic                 data_out_clear_i,
  input  wire logic                 fault_i,
  output logic                      alert_o,
  // Cipher datapath
  output state_sel_e                state_sel_o,
  output logic                      state_we_o,
  output logic                      sub_bytes_en_o,
  input  wire logic                 sub_bytes_out_req_i,
  output logic                      sub_bytes_out_ack_o,
  output add_rk_sel_e               add_rk_sel_o,
  // Key expansion datapath
  output key_full_sel_e             key_full_sel_o,
  output logic                      key_full_we_o,
  output key_dec_sel_e              key_dec_sel_o,
  output logic                      key_dec_we_o,
  output logic                      key_expand_en_o,
  input  wire logic                 key_expand_out_req_i,
  output logic                      key_expand_out_ack_o,
  output logic                      key_expand_clear_o,
  output logic      [RND_CTR_W-1:0] rnd_ctr_o,
  output key_words_sel_e            key_words_sel_o,
  output round_key_sel_e            round_key_sel_o
);

  logic          rnd_load;
  logic          rnd_incr;
  logic          last_regular;
  logic          rnd_ctr_err;
  cipher_state_e state;

  cipher_cmd_if cmd_if ();

  cipher_cmd_reg u_cmd_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd    (cmd_if)
  );

  cipher_round_ctr u_round_ctr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_i         (rnd_load),
    .key_len_i      (key_len_i),
    .incr_i         (rnd_incr),
    .rnd_ctr_o      (rnd_ctr_o),
    .last_regular_o (last_regular),
    .rnd_ctr_err_o  (rnd_ctr_err)
  );

  cipher_key_sel u_key_sel (
    .state_i         (state),
    .dec_key_gen_i   (cmd_if.dec_key_gen),
    .key_len_i       (key_len_i),
    .op_i            (op_i),
    .key_words_sel_o (key_words_sel_o),
    .round_key_sel_o (round_key_sel_o)
  );

  cipher_ctrl_fsm u_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .in_valid_i           (in_valid_i),
    .in_ready_o           (in_ready_o),
    .out_valid_o          (out_valid_o),
    .out_ready_i          (out_ready_i),
    .op_i                 (op_i),
    .key_len_i            (key_len_i),
    .crypt_i              (crypt_i),
    .dec_key_gen_i        (dec_key_gen_i),
    .key_clear_i          (key_clear_i),
    .data_out_clear_i     (data_out_clear_i),
    .fault_i              (fault_i),
    .alert_o              (alert_o),
    .state_sel_o          (state_sel_o),
    .state_we_o           (state_we_o),
    .sub_bytes_en_o       (sub_bytes_en_o),
    .sub_bytes_out_req_i  (sub_bytes_out_req_i),
    .sub_bytes_out_ack_o  (sub_bytes_out_ack_o),
    .add_rk_sel_o         (add_rk_sel_o),
    .key_full_sel_o       (key_full_sel_o),
    .key_full_we_o        (key_full_we_o),
    .key_dec_sel_o        (key_dec_sel_o),
    .key_dec_we_o         (key_dec_we_o),
    .key_expand_en_o      (key_expand_en_o),
    .key_expand_out_req_i (key_expand_out_req_i),
    .key_expand_out_ack_o (key_expand_out_ack_o),
    .key_expand_clear_o   (key_expand_clear_o),
    .cmd                  (cmd_if),
    .rnd_load_o           (rnd_load),
    .rnd_incr_o           (rnd_incr),
    .last_regular_i       (last_regular),
    .rnd_ctr_err_i        (rnd_ctr_err),
    .state_o              (state)
  );

endmodule

`default_nettype wire

//--- cipher_ctrl_tb.sv
// Directed testbench for the AES cipher control unit, run as top module with a sub-unit model
`timescale 1ns/100ps
`default_nettype none

module cipher_ctrl_tb;
  import cipher_ctrl_pkg::*;

  localparam int NUM_TESTS = 16;
  localparam int TEST_CYCLES = 200;

  logic clk_i, rst_ni, in_valid_i, out_ready_i, crypt_i, dec_key_gen_i;
  logic key_clear_i, data_out_clear_i, fault_i, sb_req, ke_req;
  ciph_op_e op_i;
  key_len_e key_len_i;
  logic in_ready_o, out_valid_o, alert_o, state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o;
  logic key_full_we_o, key_dec_we_o, key_expand_en_o, key_expand_out_ack_o, key_expand_clear_o;
  state_sel_e state_sel_o;
  add_rk_sel_e add_rk_sel_o;
  key_full_sel_e key_full_sel_o;
  key_dec_sel_e key_dec_sel_o;
  key_words_sel_e key_words_sel_o;
  round_key_sel_e round_key_sel_o;
  logic [RND_CTR_W-1:0] rnd_ctr_o;

  // Counters and first-ack capture filled by the monitor
  int ke_acks, sb_acks, dec_we_cnt, state_we_cnt;
  int sb_delay, ke_delay;
  logic ke_ack_seen, sb_ack_seen;
  logic [31:0] first_kw, first_rk;
  logic [31:0] seed_val;

  cipher_ctrl_top UUT (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .out_valid_o, .out_ready_i,
    .op_i, .key_len_i, .crypt_i, .dec_key_gen_i, .key_clear_i, .data_out_clear_i,
    .fault_i, .alert_o, .state_sel_o, .state_we_o, .sub_bytes_en_o,
    .sub_bytes_out_req_i (sb_req), .sub_bytes_out_ack_o, .add_rk_sel_o,
    .key_full_sel_o, .key_full_we_o, .key_dec_sel_o, .key_dec_we_o, .key_expand_en_o,
    .key_expand_out_req_i (ke_req), .key_expand_out_ack_o, .key_expand_clear_o,
    .rnd_ctr_o, .key_words_sel_o, .round_key_sel_o
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////
  // Reporting and expectations
  ////////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      report_fail($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic int rounds_for(input key_len_e kl);
    return (kl == AES_128) ? 10 : (kl == AES_192) ? 12 : 14;
  endfunction

  // Initial round words, inverse starts at the top of the key
  function automatic key_words_sel_e init_words(input key_len_e kl, input ciph_op_e op);
    if (op == CIPH_FWD || kl == AES_128) return KEY_WORDS_0123;
    return (kl == AES_192) ? KEY_WORDS_2345 : KEY_WORDS_4567;
  endfunction

  function automatic key_words_sel_e round_words(input key_len_e kl, input ciph_op_e op);
    if (op == CIPH_INV || kl == AES_128) return KEY_WORDS_0123;
    return (kl == AES_192) ? KEY_WORDS_2345 : KEY_WORDS_4567;
  endfunction

  ////////////////////////////////
  // Monitor and sub-unit model
  ////////////////////////////////

  // Samples 2 ns before the rising edge where everything is settled
  always @(negedge clk_i) begin
    #3;
    if (key_expand_out_ack_o && ke_acks == 0) begin
      first_kw = key_words_sel_o;
      first_rk = round_key_sel_o;
    end
    ke_acks      += key_expand_out_ack_o;
    sb_acks      += sub_bytes_out_ack_o;
    dec_we_cnt   += key_dec_we_o;
    state_we_cnt += state_we_o;
    ke_ack_seen  = key_expand_out_ack_o;
    sb_ack_seen  = sub_bytes_out_ack_o;
  end

  // Requests rise after 0 to 3 idle cycles and drop after their acknowledge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      ke_req <= 1'b0;
      sb_req <= 1'b0;
    end else begin
      if (ke_req && ke_ack_seen) begin
        ke_req   <= 1'b0;
        ke_delay = $urandom % 4;
      end else if (!ke_req && key_expand_en_o) begin
        if (ke_delay == 0) ke_req <= 1'b1;
        else ke_delay--;
      end
      if (sb_req && sb_ack_seen) begin
        sb_req   <= 1'b0;
        sb_delay = $urandom % 4;
      end else if (!sb_req && sub_bytes_en_o) begin
        if (sb_delay == 0) sb_req <= 1'b1;
        else sb_delay--;
      end
    end
  end

  ////////////////////////////////
  // Test tasks
  ////////////////////////////////

  task automatic check_idle_outputs();
    check_eq("in_ready_o", in_ready_o, 1);
    check_eq("out_valid_o", out_valid_o, 0);
    check_eq("alert_o", alert_o, 0);
    check_eq("write enables", {state_we_o, key_full_we_o, key_dec_we_o}, 0);
    check_eq("enables", {sub_bytes_en_o, key_expand_en_o, key_expand_clear_o}, 0);
    check_eq("acknowledges", {sub_bytes_out_ack_o, key_expand_out_ack_o}, 0);
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    fault_i = 1'b0;
    in_valid_i = 1'b0;
    repeat (4) begin
      #4;
      check_idle_outputs();
      @(negedge clk_i);
    end
    rst_ni = 1'b1;
    #4;
    check_idle_outputs();
  endtask

  // Drives one command at the falling edge and checks its acceptance
  task automatic issue_cmd(input logic cr, input logic dk, input logic kc, input logic dc,
                           input ciph_op_e op, input key_len_e kl, input logic rdy);
    @(negedge clk_i);
    {crypt_i, dec_key_gen_i, key_clear_i, data_out_clear_i} = {cr, dk, kc, dc};
    op_i = op;
    key_len_i = kl;
    out_ready_i = rdy;
    in_valid_i = 1'b1;
    ke_acks = 0;
    sb_acks = 0;
    dec_we_cnt = 0;
    state_we_cnt = 0;
    #4;
    check_eq("in_ready_o", in_ready_o, 1);
    // Key expansion restarts only for a block or a key generation
    check_eq("key_expand_clear_o", key_expand_clear_o, (cr || dk) && !(kc || dc));
    @(negedge clk_i);
    in_valid_i = 1'b0;
    #4;
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    while (!out_valid_o) begin
      n++;
      assert (n < TEST_CYCLES) else report_fail("out_valid_o did not rise in time");
      @(negedge clk_i);
      #4;
    end
  endtask

  task automatic run_crypt(input ciph_op_e op, input key_len_e kl, input logic stall);
    int nr;
    logic [31:0] snap;
    nr = rounds_for(kl);
    issue_cmd(1, 0, 0, 0, op, kl, !stall);
    wait_out_valid();
    if (stall) begin
      snap = {state_sel_o, state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o, add_rk_sel_o,
              key_full_sel_o, key_full_we_o, key_dec_sel_o, key_dec_we_o, key_expand_en_o,
              key_expand_out_ack_o, key_expand_clear_o, rnd_ctr_o, key_words_sel_o,
              round_key_sel_o, in_ready_o, out_valid_o, alert_o};
      repeat (1 + $urandom % 6) begin
        @(negedge clk_i);
        #4;
        check_eq("outputs under back-pressure", {state_sel_o, state_we_o, sub_bytes_en_o,
                 sub_bytes_out_ack_o, add_rk_sel_o, key_full_sel_o, key_full_we_o,
                 key_dec_sel_o, key_dec_we_o, key_expand_en_o, key_expand_out_ack_o,
                 key_expand_clear_o, rnd_ctr_o, key_words_sel_o, round_key_sel_o,
                 in_ready_o, out_valid_o, alert_o}, snap);
      end
      @(negedge clk_i);
      out_ready_i = 1'b1;
      #4;
    end
    check_eq("rnd_ctr_o", rnd_ctr_o, nr);
    check_eq("key_words_sel_o at finish", key_words_sel_o, round_words(kl, op));
    check_eq("round_key_sel_o at finish", round_key_sel_o, ROUND_KEY_DIRECT);
    check_eq("sub_bytes_out_ack_o count", sb_acks, nr);
    check_eq("key_expand_out_ack_o count", ke_acks, (kl == AES_256) ? nr - 1 : nr);
    // AES-256 has no KeyExpand wait in the initial round
    if (kl == AES_256) begin
      check_eq("key_words_sel_o at first ack", first_kw, round_words(kl, op));
      check_eq("round_key_sel_o at first ack", first_rk,
               (op == CIPH_INV) ? ROUND_KEY_MIXED : ROUND_KEY_DIRECT);
    end else begin
      check_eq("key_words_sel_o at first ack", first_kw, init_words(kl, op));
      check_eq("round_key_sel_o at first ack", first_rk, ROUND_KEY_DIRECT);
    end
    @(negedge clk_i);
    #4;
    check_eq("in_ready_o after handshake", in_ready_o, 1);
  endtask

  task automatic run_key_gen(input key_len_e kl);
    issue_cmd(0, 1, 0, 0, CIPH_INV, kl, 1);
    wait_out_valid();
    check_eq("key_dec_we_o count", dec_we_cnt, 1);
    check_eq("sub_bytes_out_ack_o count", sb_acks, 0);
    check_eq("state_we_o count", state_we_cnt, 1);
    @(negedge clk_i);
    #4;
    check_eq("in_ready_o after handshake", in_ready_o, 1);
  endtask

  task automatic run_clears();
    issue_cmd(0, 0, 0, 1, CIPH_FWD, AES_128, 1);
    check_eq("state_we_o", state_we_o, 1);
    check_eq("state_sel_o", state_sel_o, STATE_CLEAR);
    @(negedge clk_i);
    #4;
    check_eq("out_valid_o", out_valid_o, 1);
    issue_cmd(0, 0, 1, 0, CIPH_FWD, AES_128, 1);
    check_eq("key_full_sel_o", key_full_sel_o, KEY_FULL_CLEAR);
    check_eq("key_full_we_o", key_full_we_o, 1);
    check_eq("key_dec_sel_o", key_dec_sel_o, KEY_DEC_CLEAR);
    check_eq("key_dec_we_o", key_dec_we_o, 1);
    check_eq("out_valid_o", out_valid_o, 1);
  endtask

  task automatic check_error_held();
    repeat (5) begin
      check_eq("alert_o", alert_o, 1);
      check_eq("in_ready_o", in_ready_o, 0);
      @(negedge clk_i);
      #4;
    end
  endtask

  task automatic run_faults();
    // Block held at its output so the fault has a pending valid to suppress
    issue_cmd(1, 0, 0, 0, CIPH_FWD, AES_128, 0);
    wait_out_valid();
    @(negedge clk_i);
    fault_i = 1'b1;
    #4;
    check_eq("out_valid_o", out_valid_o, 0);
    @(negedge clk_i);
    fault_i = 1'b0;
    #4;
    check_error_held();
    apply_reset();
    // Accepted command without any flag is illegal
    issue_cmd(0, 0, 0, 0, CIPH_FWD, AES_128, 1);
    check_error_held();
    apply_reset();
  endtask

  ////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {in_valid_i, out_ready_i, crypt_i, dec_key_gen_i} = '0;
    {key_clear_i, data_out_clear_i, fault_i, sb_req, ke_req} = '0;
    {ke_ack_seen, sb_ack_seen} = '0;
    op_i = CIPH_FWD;
    key_len_i = AES_128;
    seed_val = $urandom(32'h2259_440c);
    ke_delay = $urandom % 4;
    sb_delay = $urandom % 4;
    apply_reset();
    for (int k = 0; k < 3; k++) begin
      run_crypt(CIPH_FWD, key_len_e'(k), 0);
      run_crypt(CIPH_INV, key_len_e'(k), 0);
    end
    run_key_gen(AES_128);
    run_key_gen(AES_256);
    run_crypt(CIPH_FWD, AES_192, 1);
    run_crypt(CIPH_INV, AES_256, 1);
    run_clears();
    run_faults();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * 10);
    report_fail("Watchdog expired before the tests completed");
  end

endmodule

`default_nettype wire

//--- cipher_ctrl_top.f
cipher_ctrl_pkg.sv
cipher_cmd_if.sv
cipher_cmd_reg.sv
cipher_round_ctr.sv
cipher_key_sel.sv
cipher_ctrl_fsm.sv
cipher_ctrl_top.sv
cipher_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the cipher control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cipher_ctrl_tb \
  -f cipher_ctrl_top.f -o sim_cipher_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_cipher_ctrl > sim.log 2>&1
run_status=$?

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation did not complete, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
